// ==== hdl/tyr_alu.sv ====
`default_nettype none
`timescale 1ns/1ps

module tyr_alu (
    input  wire tyr_isa_pkg::decoded_t i_dec,
    input  wire tyr_isa_pkg::word_t    i_val_x,
    input  wire tyr_isa_pkg::word_t    i_val_y,
    output tyr_isa_pkg::word_t         o_rhs
);

    tyr_isa_pkg::word_t imm_ext;
    tyr_isa_pkg::word_t opnd_o;   // Right operand of op
    tyr_isa_pkg::word_t addend;   // Added after op
    tyr_isa_pkg::word_t op_res;
    logic               shift_oob;

    assign imm_ext = {{20{i_dec.imm[11]}}, i_dec.imm};

    // Type 0 computes X op Y + I and type 1 X op I + Y
    assign opnd_o = i_dec.itype ? imm_ext : i_val_y;
    assign addend = i_dec.itype ? i_val_y : imm_ext;

    // Unsigned compare so a negative immediate also shifts everything out
    assign shift_oob = (opnd_o >= 32'd32);

    always_comb begin
        case (i_dec.op)
            tyr_isa_pkg::OP_OR:   op_res = i_val_x | opnd_o;
            tyr_isa_pkg::OP_AND:  op_res = i_val_x & opnd_o;
            tyr_isa_pkg::OP_ADD:  op_res = i_val_x + opnd_o;
            tyr_isa_pkg::OP_MUL:  op_res = i_val_x * opnd_o; // Low half only
            tyr_isa_pkg::OP_SHL:  op_res = shift_oob ? '0 : (i_val_x << opnd_o[4:0]);
            tyr_isa_pkg::OP_LE:   op_res = {32{$signed(i_val_x) <= $signed(opnd_o)}};
            tyr_isa_pkg::OP_EQ:   op_res = {32{i_val_x == opnd_o}};
            tyr_isa_pkg::OP_NOR:  op_res = ~(i_val_x | opnd_o);
            tyr_isa_pkg::OP_NAND: op_res = ~(i_val_x & opnd_o);
            tyr_isa_pkg::OP_XOR:  op_res = i_val_x ^ opnd_o;
            tyr_isa_pkg::OP_SUB:  op_res = i_val_x - opnd_o;
            tyr_isa_pkg::OP_XNOR: op_res = i_val_x ^ ~opnd_o;
            tyr_isa_pkg::OP_SHR:  op_res = shift_oob ? '0 : (i_val_x >> opnd_o[4:0]);
            tyr_isa_pkg::OP_GT:   op_res = {32{$signed(i_val_x) > $signed(opnd_o)}};
            tyr_isa_pkg::OP_NE:   op_res = {32{i_val_x != opnd_o}};
            default:              op_res = '0; // Reserved op halts in decode
        endcase
    end

    assign o_rhs = op_res + addend;

endmodule

`default_nettype wire

// ==== hdl/tyr_bus_pkg.sv ====
`default_nettype none

package tyr_bus_pkg;

    // Word address shared by instruction port and APB
    typedef logic [31:0] addr_t;

    // Master to slave
    typedef struct packed {
        logic                psel;
        logic                penable;
        logic                pwrite;
        addr_t               paddr;
        tyr_isa_pkg::word_t  pwdata;
    } apb_req_t;

    // Slave to master
    typedef struct packed {
        tyr_isa_pkg::word_t  prdata;
        logic                pready;
        logic                pslverr; // Only meaningful with pready
    } apb_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/tyr_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module tyr_core (
    input  wire logic                  clk,
    input  wire logic                  _reset,
    output tyr_bus_pkg::addr_t         o_insn_addr,
    input  wire tyr_isa_pkg::insn_t    i_insn_data,
    output tyr_bus_pkg::apb_req_t      o_apb,
    input  wire tyr_bus_pkg::apb_rsp_t i_apb,
    output logic                       o_halt
);

    tyr_isa_pkg::decoded_t dec;
    tyr_isa_pkg::word_t    val_x;
    tyr_isa_pkg::word_t    val_y;
    tyr_isa_pkg::word_t    val_z;
    tyr_isa_pkg::word_t    rhs;
    tyr_isa_pkg::word_t    pc_plus1;  // What r15 reads as
    logic                  wr_en;
    tyr_isa_pkg::reg_idx_t wr_idx;
    tyr_isa_pkg::word_t    wr_data;

    tyr_ctrl ctrl_i (
        .clk         (clk),
        ._reset      (_reset),
        .i_dec       (dec),
        .i_rhs       (rhs),
        .i_val_z     (val_z),
        .o_insn_addr (o_insn_addr),
        .o_pc_plus1  (pc_plus1),
        .o_wr_en     (wr_en),
        .o_wr_idx    (wr_idx),
        .o_wr_data   (wr_data),
        .o_apb       (o_apb),
        .i_apb       (i_apb),
        .o_halt      (o_halt)
    );

    tyr_decode decode_i (
        .i_insn (i_insn_data),
        .o_dec  (dec)
    );

    tyr_regfile regfile_i (
        .clk        (clk),
        ._reset     (_reset),
        .i_idx_x    (dec.x),
        .i_idx_y    (dec.y),
        .i_idx_z    (dec.z),
        .i_pc_plus1 (pc_plus1),
        .i_wr_en    (wr_en),
        .i_wr_idx   (wr_idx),
        .i_wr_data  (wr_data),
        .o_val_x    (val_x),
        .o_val_y    (val_y),
        .o_val_z    (val_z)
    );

    tyr_alu alu_i (
        .i_dec   (dec),
        .i_val_x (val_x),
        .i_val_y (val_y),
        .o_rhs   (rhs)
    );

endmodule

`default_nettype wire

// ==== hdl/tyr_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "tyr_defs.svh"

module tyr_ctrl (
    input  wire logic                  clk,
    input  wire logic                  _reset,
    input  wire tyr_isa_pkg::decoded_t i_dec,
    input  wire tyr_isa_pkg::word_t    i_rhs,
    input  wire tyr_isa_pkg::word_t    i_val_z,
    output tyr_bus_pkg::addr_t         o_insn_addr,
    output tyr_isa_pkg::word_t         o_pc_plus1,
    output logic                       o_wr_en,
    output tyr_isa_pkg::reg_idx_t      o_wr_idx,
    output tyr_isa_pkg::word_t         o_wr_data,
    output tyr_bus_pkg::apb_req_t      o_apb,
    input  wire tyr_bus_pkg::apb_rsp_t i_apb,
    output logic                       o_halt
);

    typedef enum logic [1:0] {
        RUN,
        SETUP,
        ACCESS,
        HALTED
    } ctrl_state_e;

    ctrl_state_e           state;
    tyr_bus_pkg::addr_t    pc;

    // Captured when a memory instruction leaves RUN
    tyr_bus_pkg::addr_t    mem_addr;
    tyr_isa_pkg::word_t    mem_wdata;
    logic                  mem_write;
    tyr_isa_pkg::reg_idx_t mem_z;

    logic run_ok;
    logic is_mem;
    logic store_z;
    logic access_done;
    logic load_ok;

    assign run_ok      = (state == RUN) && !i_dec.illegal;
    assign is_mem      = (i_dec.deref != tyr_isa_pkg::DEREF_REG);
    assign store_z     = (i_dec.deref == tyr_isa_pkg::DEREF_STORE_Z);
    assign access_done = (state == ACCESS) && i_apb.pready;
    assign load_ok     = access_done && !i_apb.pslverr && !mem_write;

    assign o_insn_addr = pc;
    assign o_pc_plus1  = pc + 32'd1;
    assign o_halt      = (state == HALTED);

    // P is never written through the register file
    assign o_wr_en = (run_ok && !is_mem && i_dec.z != `TYR_P_REG)
                   || (load_ok && mem_z != `TYR_P_REG);
    assign o_wr_idx  = (state == RUN) ? i_dec.z : mem_z;
    assign o_wr_data = (state == RUN) ? i_rhs : i_apb.prdata;

    always_comb begin
        o_apb.psel    = (state == SETUP) || (state == ACCESS);
        o_apb.penable = (state == ACCESS);
        o_apb.pwrite  = mem_write;
        o_apb.paddr   = mem_addr;
        o_apb.pwdata  = mem_wdata;
    end

    always_ff @(posedge clk) begin
        if (!_reset) begin
            state <= RUN;
            pc    <= `TYR_RESET_VECTOR;
        end else begin
            case (state)
                RUN: begin
                    if (i_dec.illegal)
                        state <= HALTED;  // Nothing written
                    else if (!is_mem)
                        pc <= (i_dec.z == `TYR_P_REG) ? i_rhs : o_pc_plus1;
                    else
                        state <= SETUP;
                end
                SETUP: state <= ACCESS;
                ACCESS: begin
                    if (i_apb.pready) begin
                        if (i_apb.pslverr) begin
                            state <= HALTED;
                        end else begin
                            state <= RUN;
                            // Load into r15 is a jump
                            pc <= (!mem_write && mem_z == `TYR_P_REG) ?
                                  i_apb.prdata : o_pc_plus1;
                        end
                    end
                end
                default: state <= HALTED; // Stuck until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (run_ok && is_mem) begin
            mem_addr  <= store_z ? i_val_z : i_rhs;
            mem_wdata <= store_z ? i_rhs : i_val_z;
            mem_write <= store_z || (i_dec.deref == tyr_isa_pkg::DEREF_STORE_RHS);
            mem_z     <= i_dec.z;
        end
    end

    // Access phase only ever follows a setup cycle
    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (!_reset)
        o_apb.penable |-> (o_apb.psel && $past(o_apb.psel))
    ) else $error("penable without a preceding setup phase");

    // From setup until the completing edge nothing in the request may move
    a_req_stable: assert property (
        @(posedge clk) disable iff (!_reset)
        (o_apb.psel && !(o_apb.penable && i_apb.pready))
        |=> (o_apb.psel && o_apb.penable
             && $stable(o_apb.paddr) && $stable(o_apb.pwrite) && $stable(o_apb.pwdata))
    ) else $error("APB request changed before pready");

endmodule

`default_nettype wire

// ==== hdl/tyr_decode.sv ====
`default_nettype none
`timescale 1ns/1ps

module tyr_decode (
    input  wire tyr_isa_pkg::insn_t i_insn,
    output tyr_isa_pkg::decoded_t   o_dec
);

    tyr_isa_pkg::alu_op_e op_f;
    tyr_isa_pkg::deref_e  deref_f;
    logic                 bad_word;
    logic                 bad_op;

    assign op_f    = tyr_isa_pkg::alu_op_e'(i_insn[15:12]);
    assign deref_f = tyr_isa_pkg::deref_e'(i_insn[29:28]);

    // Top bit must be clear
    assign bad_word = i_insn[31];

    // Reserved op 4 halts the core just like a bad word
    assign bad_op = (op_f == tyr_isa_pkg::OP_RESERVED);

    always_comb begin
        o_dec.z       = i_insn[27:24];
        o_dec.x       = i_insn[23:20];
        o_dec.y       = i_insn[19:16];
        o_dec.op      = op_f;
        o_dec.imm     = i_insn[11:0];
        o_dec.itype   = i_insn[30];  // Type bit
        o_dec.deref   = deref_f;
        o_dec.illegal = bad_word || bad_op;
    end

endmodule

`default_nettype wire

// ==== hdl/tyr_defs.svh ====
`ifndef TYR_DEFS_SVH
`define TYR_DEFS_SVH

// First fetch address after reset
`define TYR_RESET_VECTOR 32'd0

// Architectural registers, r0 and P included
`define TYR_NUM_REGS 16

// P lives at the top of the register space
`define TYR_P_REG 4'd15

// Data memory depth in words
`define TYR_MEM_WORDS 256

`endif

// ==== hdl/tyr_isa_pkg.sv ====
`default_nettype none

package tyr_isa_pkg;

    typedef logic [31:0] word_t;    // Data word
    typedef logic [31:0] insn_t;    // Instruction word
    typedef logic [3:0]  reg_idx_t; // Register index
    typedef logic [11:0] imm_t;     // Signed immediate field

    // Op field, bits 15:12
    typedef enum logic [3:0] {
        OP_OR       = 4'd0,
        OP_AND      = 4'd1,
        OP_ADD      = 4'd2,
        OP_MUL      = 4'd3,
        OP_RESERVED = 4'd4,
        OP_SHL      = 4'd5,
        OP_LE       = 4'd6,
        OP_EQ       = 4'd7,
        OP_NOR      = 4'd8,
        OP_NAND     = 4'd9,
        OP_XOR      = 4'd10,
        OP_SUB      = 4'd11,
        OP_XNOR     = 4'd12,  // X xor ~O
        OP_SHR      = 4'd13,
        OP_GT       = 4'd14,
        OP_NE       = 4'd15
    } alu_op_e;

    // Where the result goes, bits 29:28
    typedef enum logic [1:0] {
        DEREF_REG       = 2'b00, // Z <- rhs
        DEREF_LOAD      = 2'b01, // Z <- [rhs]
        DEREF_STORE_Z   = 2'b10, // [Z] <- rhs
        DEREF_STORE_RHS = 2'b11  // [rhs] <- Z
    } deref_e;

    typedef struct packed {
        reg_idx_t z;
        reg_idx_t x;
        reg_idx_t y;
        alu_op_e  op;
        imm_t     imm;
        logic     itype;   // 1 swaps the roles of Y and the immediate
        deref_e   deref;
        logic     illegal;
    } decoded_t;

endpackage

`default_nettype wire

// ==== hdl/tyr_regfile.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "tyr_defs.svh"

module tyr_regfile (
    input  wire logic                  clk,
    input  wire logic                  _reset,
    input  wire tyr_isa_pkg::reg_idx_t i_idx_x,
    input  wire tyr_isa_pkg::reg_idx_t i_idx_y,
    input  wire tyr_isa_pkg::reg_idx_t i_idx_z,
    input  wire tyr_isa_pkg::word_t    i_pc_plus1,
    input  wire logic                  i_wr_en,
    input  wire tyr_isa_pkg::reg_idx_t i_wr_idx,
    input  wire tyr_isa_pkg::word_t    i_wr_data,
    output tyr_isa_pkg::word_t         o_val_x,
    output tyr_isa_pkg::word_t         o_val_y,
    output tyr_isa_pkg::word_t         o_val_z
);

    // Only r1..r14 have storage
    tyr_isa_pkg::word_t gpr [1:`TYR_NUM_REGS-2];

    function automatic tyr_isa_pkg::word_t read_reg(input tyr_isa_pkg::reg_idx_t idx);
        if (idx == '0)
            return '0;
        else if (idx == `TYR_P_REG)
            return i_pc_plus1; // P reads as next address
        else
            return gpr[idx];
    endfunction

    always_comb begin
        o_val_x = read_reg(i_idx_x);
        o_val_y = read_reg(i_idx_y);
        o_val_z = read_reg(i_idx_z);
    end

    always_ff @(posedge clk) begin
        if (!_reset) begin
            for (int i = 1; i <= `TYR_NUM_REGS - 2; i++)
                gpr[i] <= '0;
        end else if (i_wr_en && i_wr_idx != '0 && i_wr_idx != `TYR_P_REG) begin
            gpr[i_wr_idx] <= i_wr_data;
        end
    end

    // Control redirects P itself and never hands us a write to r15
    a_no_p_write: assert property (
        @(posedge clk) disable iff (!_reset)
        i_wr_en |-> (i_wr_idx != `TYR_P_REG)
    ) else $error("write to P reached the register file");

endmodule

`default_nettype wire

// ==== tyr_cpu.f ====
+incdir+hdl
hdl/tyr_isa_pkg.sv
hdl/tyr_bus_pkg.sv
hdl/tyr_regfile.sv
hdl/tyr_decode.sv
hdl/tyr_alu.sv
hdl/tyr_ctrl.sv
hdl/tyr_core.sv
verif/tyr_apb_mem.sv
verif/tyr_tb.sv

// ==== verif/tyr_apb_mem.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "tyr_defs.svh"

module tyr_apb_mem (
    input  wire logic                  clk,
    input  wire logic                  _reset,
    input  wire tyr_bus_pkg::apb_req_t i_apb,
    output tyr_bus_pkg::apb_rsp_t      o_apb
);

    tyr_isa_pkg::word_t mem [0:`TYR_MEM_WORDS-1];

    logic [1:0] wait_need; // Wait states of the current transfer
    logic [1:0] wait_cnt;
    logic       access;
    logic       in_range;

    assign access   = i_apb.psel && i_apb.penable;
    assign in_range = (i_apb.paddr < `TYR_MEM_WORDS);

    always_comb begin
        o_apb.pready  = access && (wait_cnt == wait_need);
        o_apb.pslverr = o_apb.pready && !in_range; // Outside the array
        o_apb.prdata  = in_range ? mem[i_apb.paddr] : 32'hdead_beef;
    end

    // Wait states step through 0, 1, 2 from one transfer to the next
    always @(posedge clk) begin
        if (!_reset) begin
            wait_need <= 2'd0;
            wait_cnt  <= 2'd0;
        end else if (o_apb.pready) begin
            wait_cnt  <= 2'd0;
            wait_need <= (wait_need == 2'd2) ? 2'd0 : wait_need + 2'd1;
            if (i_apb.pwrite && in_range)
                mem[i_apb.paddr] <= i_apb.pwdata;
        end else if (access) begin
            wait_cnt <= wait_cnt + 2'd1;
        end
    end

endmodule

`default_nettype wire

// ==== verif/tyr_tb.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "tyr_defs.svh"

module tyr_tb;

    typedef struct packed {
        logic [3:0]  op;
        logic        itype;
        logic [11:0] imm;
        logic        rnd;    // Random operands instead of the fixed pair
    } case_t;

    localparam int          num_cases    = 31;
    localparam logic [31:0] illegal_word = 32'h8000_0000;
    localparam logic [31:0] fixed_x      = 32'hffff_fff3; // -13
    localparam logic [31:0] fixed_y      = 32'd5;

    logic                  clk;
    logic                  _reset;
    tyr_bus_pkg::addr_t    insn_addr;
    tyr_isa_pkg::insn_t    insn_data;
    tyr_bus_pkg::apb_req_t apb_req;
    tyr_bus_pkg::apb_rsp_t apb_rsp;
    logic                  halt;
    tyr_isa_pkg::insn_t    imem [0:31];
    case_t                 cases [0:num_cases-1];
    logic [31:0]           lfsr_state;

    assign insn_data = (insn_addr < 32) ? imem[insn_addr[4:0]] : illegal_word;

    tyr_core dut_i (
        .clk         (clk),
        ._reset      (_reset),
        .o_insn_addr (insn_addr),
        .i_insn_data (insn_data),
        .o_apb       (apb_req),
        .i_apb       (apb_rsp),
        .o_halt      (halt)
    );

    tyr_apb_mem mem_i (
        .clk    (clk),
        ._reset (_reset),
        .i_apb  (apb_req),
        .o_apb  (apb_rsp)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_word(output logic [31:0] w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] fill_word(input int a);
        return (a * 32'h9e37_79b9) ^ 32'h0bad_f00d;
    endfunction

    function automatic tyr_isa_pkg::insn_t build_insn(
        input tyr_isa_pkg::deref_e d,
        input logic                t,
        input logic [3:0]          z,
        input logic [3:0]          x,
        input logic [3:0]          y,
        input logic [3:0]          op,
        input logic [11:0]         imm
    );
        return {1'b0, t, d, z, x, y, op, imm};
    endfunction

    // (X op O) + A straight from the instruction set rules
    function automatic logic [31:0] model_rhs(input case_t c, input logic [31:0] x,
                                              input logic [31:0] y);
        logic [31:0] imm_sx;
        logic [31:0] o;
        logic [31:0] a;
        logic [31:0] r;
        imm_sx = 32'($signed(c.imm));
        o = c.itype ? imm_sx : y;
        a = c.itype ? y : imm_sx;
        case (c.op)
            4'd0:    r = x | o;
            4'd1:    r = x & o;
            4'd2:    r = x + o;
            4'd3:    r = x * o;
            4'd5:    r = (o >= 32) ? 32'd0 : x << o;
            4'd6:    r = ($signed(x) <= $signed(o)) ? 32'hffff_ffff : 32'd0;
            4'd7:    r = (x == o) ? 32'hffff_ffff : 32'd0;
            4'd8:    r = ~(x | o);
            4'd9:    r = ~(x & o);
            4'd10:   r = x ^ o;
            4'd11:   r = x - o;
            4'd12:   r = x ^ ~o;
            4'd13:   r = (o >= 32) ? 32'd0 : x >> o;
            4'd14:   r = ($signed(x) > $signed(o)) ? 32'hffff_ffff : 32'd0;
            default: r = (x != o) ? 32'hffff_ffff : 32'd0;
        endcase
        return r + a;
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string msg);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic wait_halt(input int limit);
        int n;
        n = 0;
        while (!halt && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!halt) begin
            $display("Timeout: the core did not halt within %0d cycles", limit);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic wait_addr(input logic [31:0] addr, input int limit);
        int n;
        n = 0;
        while (insn_addr !== addr && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (insn_addr !== addr) begin
            $display("Timeout: fetch address %0d never reached within %0d cycles", addr, limit);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // Reset goes low here and memories get their fill before release
    task automatic start_reset();
        @(posedge clk);
        _reset <= 1'b0;
        for (int i = 0; i < 32; i++)
            imem[i] <= illegal_word;
        for (int a = 0; a < `TYR_MEM_WORDS; a++)
            mem_i.mem[a] <= fill_word(a);
    endtask

    task automatic release_reset();
        repeat (2) @(posedge clk);
        _reset <= 1'b1;
        @(negedge clk);
        check_equal(insn_addr, `TYR_RESET_VECTOR, "fetch address after reset");
        check_equal(apb_req.psel, 1'b0, "psel after reset");
        check_equal(halt, 1'b0, "halt after reset");
    endtask

    task automatic check_frozen();
        logic [31:0] held;
        held = insn_addr;
        repeat (4) begin
            @(negedge clk);
            check_equal(insn_addr, held, "fetch address moved while halted");
            check_equal(apb_req.psel, 1'b0, "APB active while halted");
            check_equal(halt, 1'b1, "halt dropped");
        end
    endtask

    task automatic run_case(input case_t c);
        logic [31:0] x_op;
        logic [31:0] y_op;
        logic [31:0] exp;
        if (c.rnd) begin
            random_word(x_op);
            random_word(y_op);
        end else begin
            x_op = fixed_x;
            y_op = fixed_y;
        end
        exp = model_rhs(c, x_op, y_op);
        start_reset();
        mem_i.mem[0] <= x_op;
        mem_i.mem[1] <= y_op;
        imem[0]  <= build_insn(tyr_isa_pkg::DEREF_LOAD, 0, 1, 0, 0, 0, 0);
        imem[1]  <= build_insn(tyr_isa_pkg::DEREF_LOAD, 0, 2, 0, 0, 0, 1);
        imem[2]  <= build_insn(tyr_isa_pkg::DEREF_REG, c.itype, 3, 1, 2, c.op, c.imm);
        imem[3]  <= build_insn(tyr_isa_pkg::DEREF_REG, 0, 4, 0, 0, 0, 16);
        imem[4]  <= build_insn(tyr_isa_pkg::DEREF_STORE_Z, 0, 4, 3, 0, 0, 0);
        imem[5]  <= build_insn(tyr_isa_pkg::DEREF_STORE_RHS, 0, 15, 0, 0, 0, 17);
        imem[6]  <= build_insn(tyr_isa_pkg::DEREF_REG, 0, 0, 0, 0, 0, 5); // r0 ignores it
        imem[7]  <= build_insn(tyr_isa_pkg::DEREF_STORE_RHS, 0, 0, 0, 0, 0, 18);
        imem[8]  <= build_insn(tyr_isa_pkg::DEREF_REG, 0, 15, 0, 0, 0, 10); // Jump to 10
        imem[9]  <= build_insn(tyr_isa_pkg::DEREF_STORE_RHS, 0, 3, 0, 0, 0, 19);
        release_reset();
        if (c.op == 4'd4) begin
            wait_halt(200);
            check_equal(insn_addr, 32'd2, "halt address on reserved op");
            check_equal(mem_i.mem[16], fill_word(16), "store after reserved op");
        end else begin
            wait_addr(32'd8, 200);
            @(negedge clk);
            check_equal(insn_addr, 32'd10, "fetch address after jump");
            wait_halt(200);
            check_equal(insn_addr, 32'd10, "halt address on illegal word");
            check_equal(mem_i.mem[16], exp, $sformatf("op %0d type %0d result", c.op, c.itype));
            check_equal(mem_i.mem[17], 32'd6, "r15 read as address plus one");
            check_equal(mem_i.mem[18], 32'd0, "r0 after a write");
            check_equal(mem_i.mem[19], fill_word(19), "store skipped by jump");
        end
        check_frozen();
    endtask

    task automatic run_slverr_case();
        start_reset();
        imem[0] <= build_insn(tyr_isa_pkg::DEREF_STORE_RHS, 0, 0, 0, 0, 0, 300);
        imem[1] <= build_insn(tyr_isa_pkg::DEREF_STORE_RHS, 0, 0, 0, 0, 0, 20);
        release_reset();
        wait_halt(200);
        check_equal(insn_addr, 32'd0, "halt address on slave error");
        check_equal(mem_i.mem[20], fill_word(20), "store after slave error");
        check_frozen();
    endtask

    initial begin
        int k;
        clk        = 1'b0;
        _reset     = 1'b0;
        lfsr_state = 32'd33;
        cases[0]  = '{4'd0,  1'b0, 12'h0f0, 1'b1};
        cases[1]  = '{4'd0,  1'b1, 12'h0a5, 1'b1};
        cases[2]  = '{4'd1,  1'b0, 12'h001, 1'b1};
        cases[3]  = '{4'd1,  1'b1, 12'hff0, 1'b1};
        cases[4]  = '{4'd2,  1'b0, 12'h7ff, 1'b1};
        cases[5]  = '{4'd2,  1'b1, 12'h800, 1'b1};
        cases[6]  = '{4'd3,  1'b0, 12'h003, 1'b1};
        cases[7]  = '{4'd3,  1'b1, 12'hffd, 1'b0};
        cases[8]  = '{4'd5,  1'b0, 12'h000, 1'b0};
        cases[9]  = '{4'd5,  1'b1, 12'h003, 1'b1};
        cases[10] = '{4'd6,  1'b0, 12'h000, 1'b0};
        cases[11] = '{4'd6,  1'b1, 12'hff3, 1'b0};
        cases[12] = '{4'd7,  1'b0, 12'h010, 1'b0};
        cases[13] = '{4'd7,  1'b1, 12'hff3, 1'b0};
        cases[14] = '{4'd8,  1'b0, 12'h001, 1'b1};
        cases[15] = '{4'd8,  1'b1, 12'h00f, 1'b1};
        cases[16] = '{4'd9,  1'b0, 12'h002, 1'b1};
        cases[17] = '{4'd9,  1'b1, 12'h0f0, 1'b1};
        cases[18] = '{4'd10, 1'b0, 12'h123, 1'b1};
        cases[19] = '{4'd10, 1'b1, 12'h456, 1'b1};
        cases[20] = '{4'd11, 1'b0, 12'hfff, 1'b1};
        cases[21] = '{4'd11, 1'b1, 12'h100, 1'b0};
        cases[22] = '{4'd12, 1'b0, 12'h000, 1'b1};
        cases[23] = '{4'd12, 1'b1, 12'h5a5, 1'b1};
        cases[24] = '{4'd13, 1'b0, 12'h000, 1'b0};
        cases[25] = '{4'd13, 1'b1, 12'h020, 1'b0}; // Shift by 32
        cases[26] = '{4'd14, 1'b0, 12'h000, 1'b0};
        cases[27] = '{4'd14, 1'b1, 12'hff0, 1'b1};
        cases[28] = '{4'd15, 1'b0, 12'h000, 1'b1};
        cases[29] = '{4'd15, 1'b1, 12'hff3, 1'b0};
        cases[30] = '{4'd4,  1'b0, 12'h000, 1'b1}; // Reserved op halts
        for (k = 0; k < num_cases; k++)
            run_case(cases[k]);
        run_slverr_case();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
